/* source/i2cPkg.sv */
`default_nettype none

package i2cPkg;

	////////////////////////////////////////////////////////////////////////////
	// Widths and counts.
	////////////////////////////////////////////////////////////////////////////

	// Register bus.
	localparam int busAddrW = 2;
	localparam int busDataW = 16;

	// Baud divisor, bus bits 15 to 1.
	localparam int baudW = 15;

	// One byte transfer is 22 phases.
	localparam int phaseCount = 22;
	localparam int phaseW = 5;

	// First phase of each section after START.
	localparam int phaseDataFirst = 2;
	localparam int phaseAckFirst = 18;
	localparam int phaseStopFirst = 20;

	////////////////////////////////////////////////////////////////////////////
	// Types.
	////////////////////////////////////////////////////////////////////////////

	// Register map, address 3 unused.
	typedef enum logic [busAddrW-1:0] {
		regBaud = 2'd0,
		regCtl = 2'd1,
		regData = 2'd2
	} i2cRegAddrE;

	// Control flags, enable in bit 0.
	typedef struct packed {
		logic start;
		logic stop;
		logic write;
		logic enable;
	} i2cCtlT;

	// Status back to the register file.
	typedef struct packed {
		logic sclLevel;
		logic idle;
		logic ackBit;
	} i2cStatusT;

	// What the bus lines are doing this phase.
	typedef enum logic [2:0] {
		modeIdle,
		modeStart,
		modeData,
		modeAck,
		modeStop
	} i2cLineModeE;

	typedef enum logic {
		seqIdle,
		seqRun
	} i2cSeqStateE;

endpackage

`default_nettype wire

/* source/i2cBusRegs.sv */
`timescale 1ns/1ns
`default_nettype none

module i2cBusRegs import i2cPkg::*; (
	input  wire                 clk,
	input  wire                 rstN,
	input  wire [busAddrW-1:0]  busAddr,
	input  wire                 busWr,
	input  wire                 busEn,
	input  wire [busDataW-1:0]  busWrData,
	output logic [busDataW-1:0] busRdData,
	output logic [baudW-1:0]    baudDiv,
	output i2cCtlT              ctl,
	input  wire i2cStatusT      status,
	input  var byte             rxByte,
	output logic                startOp,
	output logic                loadByte,
	output byte                 wrByte
);

	////////////////////////////////////////////////////////////////////////////
	// Address decode.
	////////////////////////////////////////////////////////////////////////////

	i2cRegAddrE regAddr;
	logic busWrite;
	logic busRead;
	logic dataWr;
	logic [busDataW-1:0] rdMux;

	assign regAddr = i2cRegAddrE'(busAddr);
	assign busWrite = busEn && busWr;
	assign busRead = busEn && !busWr;

	// Data write hits the shifter only while enabled and no transfer runs.
	assign dataWr = busWrite && (regAddr == regData);
	assign loadByte = dataWr && status.idle && ctl.enable;
	assign wrByte = busWrData[7:0];

	// Same write kicks the sequencer.
	assign startOp = loadByte;

	////////////////////////////////////////////////////////////////////////////
	// Baud and control registers.
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			baudDiv <= '0;
			ctl <= '0;
		end else if (busWrite) begin
			// Divisor drops the bus LSB.
			if (regAddr == regBaud) begin
				baudDiv <= busWrData[busDataW-1:1];
			end
			if (regAddr == regCtl) begin
				ctl <= i2cCtlT'(busWrData[3:0]);
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read-back.
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (regAddr)
			regBaud: rdMux = {baudDiv, 1'b0};
			// Status sits above the four flags.
			regCtl: rdMux = {9'd0, status.sclLevel, status.ackBit, status.idle, ctl};
			regData: rdMux = {8'd0, rxByte};
			default: rdMux = '0;
		endcase
	end

	// Zero unless a read is on the bus.
	assign busRdData = busRead ? rdMux : '0;

endmodule

`default_nettype wire

/* source/i2cBaudTimer.sv */
`timescale 1ns/1ns
`default_nettype none

module i2cBaudTimer import i2cPkg::*; (
	input  wire              clk,
	input  wire              rstN,
	input  wire [baudW-1:0]  baudDiv,
	input  wire              running,
	input  wire              startOp,
	output logic             baudTick
);

	logic [baudW-1:0] count;
	logic [baudW-1:0] divClamped;
	logic [baudW-1:0] lastCount;

	// Divisor below two acts as two.
	assign divClamped = (baudDiv < baudW'(2)) ? baudW'(2) : baudDiv;
	assign lastCount = divClamped - baudW'(1);

	// One tick per phase, only while a transfer runs.
	assign baudTick = running && (count == lastCount);

	always_ff @(posedge clk) begin
		if (!rstN) begin
			count <= '0;
		end else if (startOp || baudTick) begin
			// New transfer or end of phase.
			count <= '0;
		end else if (running) begin
			count <= count + baudW'(1);
		end
	end

endmodule

`default_nettype wire

/* source/i2cSequencer.sv */
`timescale 1ns/1ns
`default_nettype none

module i2cSequencer import i2cPkg::*; (
	input  wire               clk,
	input  wire               rstN,
	input  wire               startOp,
	input  wire               baudTick,
	input  wire i2cCtlT       ctl,
	output logic              running,
	output logic              idle,
	output logic [phaseW-1:0] phase,
	output i2cLineModeE       lineMode,
	output logic              sclOut,
	output logic              shiftStrobe,
	output logic              ackStrobe
);

	i2cSeqStateE state;
	logic lastPhase;

	assign lastPhase = (phase == phaseW'(phaseCount - 1));

	////////////////////////////////////////////////////////////////////////////
	// Phase FSM.
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			state <= seqIdle;
			phase <= '0;
		end else begin
			case (state)
				seqIdle: begin
					phase <= '0;
					if (startOp) begin
						state <= seqRun;
					end
				end
				seqRun: begin
					// Step on each baud tick, back to idle after phase 21.
					if (baudTick) begin
						if (lastPhase) begin
							state <= seqIdle;
							phase <= '0;
						end else begin
							phase <= phase + phaseW'(1);
						end
					end
				end
			endcase
		end
	end

	assign running = (state == seqRun);
	assign idle = (state == seqIdle);

	// Phase to line mode.
	always_comb begin
		if (state == seqIdle) begin
			lineMode = modeIdle;
		end else if (phase < phaseW'(phaseDataFirst)) begin
			lineMode = modeStart;
		end else if (phase < phaseW'(phaseAckFirst)) begin
			lineMode = modeData;
		end else if (phase < phaseW'(phaseStopFirst)) begin
			lineMode = modeAck;
		end else begin
			lineMode = modeStop;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// SCL and strobes.
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		case (lineMode)
			// Odd phases high.
			modeData, modeAck: sclOut = phase[0];
			// Hold low without a STOP.
			modeStop: sclOut = ctl.stop && phase[0];
			default: sclOut = 1'b1;
		endcase
	end

	// Sample on the tick closing an SCL-high phase.
	assign shiftStrobe = baudTick && (lineMode == modeData) && phase[0];
	assign ackStrobe = baudTick && (lineMode == modeAck) && phase[0];

endmodule

`default_nettype wire

/* source/i2cShifter.sv */
`timescale 1ns/1ns
`default_nettype none

module i2cShifter import i2cPkg::*; (
	input  wire               clk,
	input  wire               rstN,
	input  wire               loadByte,
	input  var byte           wrByte,
	input  wire               shiftStrobe,
	input  wire               ackStrobe,
	input  wire i2cLineModeE  lineMode,
	input  wire [phaseW-1:0]  phase,
	input  wire i2cCtlT       ctl,
	input  wire               sdaIn,
	output logic              sdaPullLow,
	output byte               rxByte,
	output logic              ackBit
);

	////////////////////////////////////////////////////////////////////////////
	// Shift register and ACK flag.
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (!rstN) begin
			rxByte <= '0;
			ackBit <= 1'b0;
		end else begin
			if (loadByte) begin
				rxByte <= wrByte;
			end else if (shiftStrobe) begin
				// MSB out, line level in.
				rxByte <= {rxByte[6:0], sdaIn};
			end
			if (ackStrobe) begin
				ackBit <= sdaIn;
			end
		end
	end

	// Open-drain SDA.
	always_comb begin
		case (lineMode)
			// Write data, released for a one.
			modeData: sdaPullLow = ctl.write && !rxByte[7];
			// Controller ACKs a read.
			modeAck: sdaPullLow = !ctl.write;
			// Fall while SCL is high.
			modeStart: sdaPullLow = ctl.start && phase[0];
			// Low in 20, released after.
			modeStop: sdaPullLow = ctl.stop && !phase[0];
			default: sdaPullLow = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* source/i2cController.sv */
`timescale 1ns/1ns
`default_nettype none

module i2cController import i2cPkg::*; (
	input  wire                 clk,
	input  wire                 rstN,
	input  wire [busAddrW-1:0]  busAddr,
	input  wire                 busWr,
	input  wire                 busEn,
	input  wire [busDataW-1:0]  busWrData,
	output logic [busDataW-1:0] busRdData,
	output logic                sclOut,
	output logic                sdaPullLow,
	input  wire                 sdaIn
);

	////////////////////////////////////////////////////////////////////////////
	// Internal nets.
	////////////////////////////////////////////////////////////////////////////

	logic [baudW-1:0] baudDiv;
	i2cCtlT ctl;
	i2cStatusT status;
	byte rxByte;
	byte wrByte;
	logic startOp;
	logic loadByte;
	logic running;
	logic idle;
	logic baudTick;
	logic [phaseW-1:0] phase;
	i2cLineModeE lineMode;
	logic shiftStrobe;
	logic ackStrobe;
	logic ackBit;

	// Status gathered for read-back.
	assign status.sclLevel = sclOut;
	assign status.idle = idle;
	assign status.ackBit = ackBit;

	i2cBusRegs regs (
		.clk(clk), .rstN(rstN),
		.busAddr(busAddr), .busWr(busWr), .busEn(busEn),
		.busWrData(busWrData), .busRdData(busRdData),
		.baudDiv(baudDiv), .ctl(ctl), .status(status), .rxByte(rxByte),
		.startOp(startOp), .loadByte(loadByte), .wrByte(wrByte)
	);

	i2cBaudTimer baudTimer (
		.clk(clk), .rstN(rstN), .baudDiv(baudDiv),
		.running(running), .startOp(startOp), .baudTick(baudTick)
	);

	i2cSequencer sequencer (
		.clk(clk), .rstN(rstN), .startOp(startOp), .baudTick(baudTick),
		.ctl(ctl), .running(running), .idle(idle), .phase(phase),
		.lineMode(lineMode), .sclOut(sclOut),
		.shiftStrobe(shiftStrobe), .ackStrobe(ackStrobe)
	);

	i2cShifter shifter (
		.clk(clk), .rstN(rstN), .loadByte(loadByte), .wrByte(wrByte),
		.shiftStrobe(shiftStrobe), .ackStrobe(ackStrobe),
		.lineMode(lineMode), .phase(phase), .ctl(ctl), .sdaIn(sdaIn),
		.sdaPullLow(sdaPullLow), .rxByte(rxByte), .ackBit(ackBit)
	);

endmodule

`default_nettype wire

/* tb/i2cTargetModel.sv */
`timescale 1ns/1ns
`default_nettype none

module i2cTargetModel (
	input  wire        clk,
	input  wire        scl,
	input  wire        sda,
	input  wire        arm,
	input  wire        writeMode,
	input  wire [7:0]  txByte,
	output logic       sdaPull,
	output logic [7:0] gotByte,
	output logic       ackLevel,
	output int         startCount,
	output int         stopCount
);

	logic prevScl = 1'b1;
	logic prevSda = 1'b1;
	logic pullLow = 1'b0;
	logic [2:0] pos;
	int bitIdx = 0;

	assign sdaPull = pullLow;

	// Line sampled on the falling clock, away from controller edges.
	always @(negedge clk) begin
		if (arm) begin
			bitIdx = 0;
			startCount = 0;
			stopCount = 0;
			// No ACK seen yet.
			ackLevel = 1'b1;
		end
		// START restarts the bit count.
		if (scl && prevSda && !sda) begin
			startCount++;
			bitIdx = 0;
		end
		// STOP, SDA up with SCL high.
		if (scl && !prevSda && sda) begin
			stopCount++;
		end
		pos = 3'(7 - bitIdx);
		if (!prevScl && scl) begin
			// Eight data bits, then the ACK slot.
			if (bitIdx < 8) begin
				gotByte[pos] = sda;
			end else if (bitIdx == 8) begin
				ackLevel = sda;
			end
			if (bitIdx < 15) begin
				bitIdx++;
			end
		end
		if (prevScl && !scl) begin
			// New level while SCL is low.
			if (bitIdx < 8) begin
				pullLow <= !writeMode && !txByte[pos];
			end else begin
				pullLow <= (bitIdx == 8) && writeMode;
			end
		end
		prevScl = scl;
		prevSda = sda;
	end

endmodule

`default_nettype wire

/* tb/i2cControllerTb.sv */
`timescale 1ns/1ns
`default_nettype none

module i2cControllerTb import i2cPkg::*; ();

	localparam int phasesPerByte = 22;
	localparam int maxDiv = 14;
	localparam int transferCount = 30;
	// Room for 40 transfers at the largest divisor.
	localparam int cycleLimit = 40 * phasesPerByte * maxDiv + 2000;

	logic clk;
	logic rstN;
	logic [busAddrW-1:0] busAddr;
	logic busWr;
	logic busEn;
	logic [busDataW-1:0] busWrData;
	wire [busDataW-1:0] busRdData;
	wire sclOut;
	wire sdaPullLow;
	wire targetPull;
	wire sdaLine;
	logic arm;
	logic writeMode;
	logic [7:0] txByte;
	wire [7:0] gotByte;
	wire ackLevel;
	int startCount;
	int stopCount;
	logic [31:0] lfsrState;
	int mismatchCount = 0;
	int cycleCount = 0;

	// Wired-AND SDA.
	assign sdaLine = !(sdaPullLow || targetPull);

	i2cController UUT (
		.clk(clk), .rstN(rstN), .busAddr(busAddr), .busWr(busWr), .busEn(busEn),
		.busWrData(busWrData), .busRdData(busRdData),
		.sclOut(sclOut), .sdaPullLow(sdaPullLow), .sdaIn(sdaLine)
	);

	i2cTargetModel target (
		.clk(clk), .scl(sclOut), .sda(sdaLine), .arm(arm), .writeMode(writeMode),
		.txByte(txByte), .sdaPull(targetPull), .gotByte(gotByte), .ackLevel(ackLevel),
		.startCount(startCount), .stopCount(stopCount)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount > cycleLimit) begin
			$display("timeout: run still going after %0d cycles, mismatches %0d",
				cycleCount, mismatchCount);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus helpers.
	////////////////////////////////////////////////////////////////////////////

	// Taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	// One step per bit taken.
	function automatic logic [31:0] randomBits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsrState = lfsrStep(lfsrState);
			r = {r[30:0], lfsrState[0]};
		end
		return r;
	endfunction

	task automatic reportMismatch(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		$display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
		mismatchCount++;
	endtask

	// Called and returns at 5 ns past a rising edge.
	task automatic busWrite(input logic [1:0] addr, input logic [15:0] data);
		busAddr = addr;
		busWrData = data;
		busWr = 1'b1;
		busEn = 1'b1;
		@(posedge clk);
		#5;
		busEn = 1'b0;
		busWr = 1'b0;
	endtask

	// Read data sampled mid-cycle.
	task automatic busRead(input logic [1:0] addr, output logic [15:0] data);
		busAddr = addr;
		busWr = 1'b0;
		busEn = 1'b1;
		@(negedge clk);
		data = busRdData;
		@(posedge clk);
		#5;
		busEn = 1'b0;
	endtask

	////////////////////////////////////////////////////////////////////////////
	// One byte transfer.
	////////////////////////////////////////////////////////////////////////////

	task automatic runTransfer(input logic [3:0] ctlBits, input logic [14:0] div,
			input logic [7:0] byteOut, input logic [7:0] byteIn);
		logic [15:0] rd;
		logic [7:0] expData;
		int effDiv;
		int busyCycles;
		// Divisor below two runs as two.
		effDiv = (int'(div) < 2) ? 2 : int'(div);
		// Write loops the line back, read takes the target byte.
		expData = ctlBits[1] ? byteOut : byteIn;
		busWrite(regBaud, {div, 1'b1});
		busWrite(regCtl, {12'd0, ctlBits});
		writeMode = ctlBits[1];
		txByte = byteIn;
		arm = 1'b1;
		busWrite(regData, {8'd0, byteOut});
		arm = 1'b0;
		// First cycle after the data write.
		busRead(regCtl, rd);
		if (rd[4] !== 1'b0) begin
			reportMismatch("idle", 16'(rd[4]), 16'd0);
		end
		busyCycles = 1;
		while (rd[4] !== 1'b1) begin
			if (busyCycles == 3) begin
				// Second data write while busy.
				busWrite(regData, {8'd0, ~byteOut});
			end else begin
				busRead(regCtl, rd);
			end
			if (rd[4] !== 1'b1) begin
				busyCycles++;
			end
		end
		if (busyCycles != phasesPerByte * effDiv) begin
			reportMismatch("busy cycles", 16'(busyCycles), 16'(phasesPerByte * effDiv));
		end
		// SCL high, ACK zero, idle, flags unchanged.
		if (rd !== {9'd0, 3'b101, ctlBits}) begin
			reportMismatch("ctl register", rd, {9'd0, 3'b101, ctlBits});
		end
		busRead(regData, rd);
		if (rd !== {8'd0, expData}) begin
			reportMismatch("data register", rd, {8'd0, expData});
		end
		if (ctlBits[1] && gotByte !== byteOut) begin
			reportMismatch("target byte", {8'd0, gotByte}, {8'd0, byteOut});
		end
		if (ackLevel !== 1'b0) begin
			reportMismatch("ack slot sda", 16'(ackLevel), 16'd0);
		end
		if (startCount != int'(ctlBits[3])) begin
			reportMismatch("start count", 16'(startCount), 16'(ctlBits[3]));
		end
		if (stopCount != int'(ctlBits[2])) begin
			reportMismatch("stop count", 16'(stopCount), 16'(ctlBits[2]));
		end
		// Nothing queued by the busy write.
		busRead(regCtl, rd);
		if (rd[4] !== 1'b1) begin
			reportMismatch("idle after transfer", 16'(rd[4]), 16'd1);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Main sequence.
	////////////////////////////////////////////////////////////////////////////

	initial begin
		logic [15:0] rd;
		logic [15:0] wd;
		logic [3:0] ctlBits;
		logic [14:0] div;
		logic [7:0] byteOut;
		logic [7:0] byteIn;
		logic [7:0] lastData;
		rstN = 1'b0;
		busAddr = '0;
		busWr = 1'b0;
		busEn = 1'b0;
		busWrData = '0;
		arm = 1'b0;
		writeMode = 1'b1;
		txByte = 8'd0;
		lfsrState = 32'hb039_8a2d;
		repeat (4) @(posedge clk);
		#5;
		rstN = 1'b1;
		// Reset values.
		busRead(regCtl, rd);
		if (rd !== 16'h0050) begin
			reportMismatch("ctl register", rd, 16'h0050);
		end
		busRead(regBaud, rd);
		if (rd !== 16'h0000) begin
			reportMismatch("baud register", rd, 16'h0000);
		end
		// Random register read-back.
		repeat (8) begin
			wd = 16'(randomBits(16));
			busWrite(regBaud, wd);
			busRead(regBaud, rd);
			if (rd !== {wd[15:1], 1'b0}) begin
				reportMismatch("baud register", rd, {wd[15:1], 1'b0});
			end
			busWrite(regCtl, wd);
			busRead(regCtl, rd);
			if (rd !== {9'd0, 3'b101, wd[3:0]}) begin
				reportMismatch("ctl register", rd, {9'd0, 3'b101, wd[3:0]});
			end
		end
		busRead(2'd3, rd);
		if (rd !== 16'h0000) begin
			reportMismatch("unused register", rd, 16'h0000);
		end
		for (int t = 0; t < transferCount; t++) begin
			ctlBits = {3'(randomBits(3)), 1'b1};
			div = {11'd0, 3'(randomBits(3)), 1'b0};
			byteOut = 8'(randomBits(8));
			byteIn = 8'(randomBits(8));
			runTransfer(ctlBits, div, byteOut, byteIn);
		end
		// Shifter keeps the byte of the last transfer.
		lastData = ctlBits[1] ? byteOut : byteIn;
		// Enable clear, the bus must stay at rest.
		busWrite(regCtl, {12'd0, 3'(randomBits(3)), 1'b0});
		busWrite(regData, {8'(randomBits(8)), ~lastData});
		repeat (2 * phasesPerByte) begin
			busRead(regCtl, rd);
			if ({rd[6], rd[4]} !== 2'b11) begin
				reportMismatch("scl and idle", {14'd0, rd[6], rd[4]}, 16'd3);
			end
			if (sclOut !== 1'b1) begin
				reportMismatch("sclOut", 16'(sclOut), 16'd1);
			end
			if (sdaPullLow !== 1'b0) begin
				reportMismatch("sdaPullLow", 16'(sdaPullLow), 16'd0);
			end
		end
		busRead(regData, rd);
		if (rd !== {8'd0, lastData}) begin
			reportMismatch("data register", rd, {8'd0, lastData});
		end
		$display("transfers %0d, mismatches %0d", transferCount, mismatchCount);
		if (mismatchCount == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* vlog.f */
source/i2cPkg.sv
source/i2cBusRegs.sv
source/i2cBaudTimer.sv
source/i2cSequencer.sv
source/i2cShifter.sv
source/i2cController.sv
tb/i2cTargetModel.sv
tb/i2cControllerTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= i2cControllerTb
FILELIST ?= vlog.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --timing --timescale 1ns/1ns -j 0

.PHONY: sim clean

# Build, run, then scan the log for the fail line.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
